// ==== hw/dac_serializer.sv ====
// DAC serializer: snapshots the four commands and shifts them to the quad DAC over SPI
module dac_serializer (
    input  logic                                              sysclk,
    input  logic                                              rst_n,
    input  logic                                              dac_update,
    input  qla_motor_pkg::cur_cmd_t [qla_motor_pkg::NUM_CHAN-1:0] cmd_all,
    output logic                                              dac_sclk,
    output logic                                              dac_mosi,
    output logic                                              dac_csel,    // active low
    output logic                                              dac_busy
);
    import qla_motor_pkg::*;

    localparam int FRAME_W = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;
    localparam int BIT_W   = $clog2(DAC_FRAME_BITS);
    localparam int DIV_W   = (DAC_HALF_PERIOD > 1) ? $clog2(DAC_HALF_PERIOD) : 1;

    typedef logic [DAC_FRAME_BITS-1:0] frame_t;

    cur_cmd_t [NUM_CHAN-1:0] cmd_snap;  // frozen for the whole update
    frame_t                  shift_reg;
    logic [FRAME_W-1:0]      frame_cnt;
    logic [BIT_W-1:0]        bit_cnt;
    logic [DIV_W-1:0]        div_cnt;   // half-period divider
    logic                    hold;      // trailing cycle after the last fall
    logic                    half_done;
    logic                    last_frame;
    logic                    start;

    // command, channel address, data, MSB first
    function automatic frame_t frame_word(input logic [FRAME_W-1:0] idx, input cur_cmd_t cmd);
        return {DAC_CMD_WRITE_UPDATE, 4'(idx), cmd};
    endfunction

    assign start      = dac_update && !dac_busy;    // requests during busy are dropped
    assign half_done  = (div_cnt == DIV_W'(DAC_HALF_PERIOD - 1));
    assign last_frame = (frame_cnt == FRAME_W'(NUM_CHAN - 1));
    assign dac_mosi   = shift_reg[DAC_FRAME_BITS-1];

    // snapshot, payload only
    always_ff @(posedge sysclk) begin
        if (start) begin
            cmd_snap <= cmd_all;
        end
    end

    // --------------------
    // frame sequencer
    // per frame: setup (csel high), 2*bits half periods, hold, then next setup
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            dac_busy  <= 1'b0;
            dac_csel  <= 1'b1;
            dac_sclk  <= 1'b0;
            shift_reg <= '0;
            frame_cnt <= '0;
            bit_cnt   <= '0;
            div_cnt   <= '0;
            hold      <= 1'b0;
        end else if (!dac_busy) begin
            if (start) begin
                dac_busy  <= 1'b1;
                frame_cnt <= '0;
                shift_reg <= frame_word('0, cmd_all[0]);   // first frame straight from input
            end
        end else if (dac_csel) begin
            dac_csel <= 1'b0;           // end of setup cycle
            bit_cnt  <= '0;
            div_cnt  <= '0;
        end else if (hold) begin
            hold     <= 1'b0;
            dac_csel <= 1'b1;
            if (last_frame) begin
                dac_busy <= 1'b0;
            end else begin
                frame_cnt <= frame_cnt + 1'b1;
                shift_reg <= frame_word(frame_cnt + 1'b1, cmd_snap[frame_cnt + 1'b1]);
            end
        end else if (half_done) begin
            div_cnt  <= '0;
            dac_sclk <= !dac_sclk;
            if (dac_sclk) begin
                shift_reg <= shift_reg << 1;    // mosi moves on the falling edge
                if (bit_cnt == BIT_W'(DAC_FRAME_BITS - 1)) begin
                    hold <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

// ==== hw/motor_channel.sv ====
// motor channel: commanded current register, amplifier enable and safety disable latch
module motor_channel (
    input  logic                    sysclk,
    input  logic                    rst_n,
    input  logic                    cmd_wen,
    input  logic                    mstat_wen,
    input  qla_regmap_pkg::word_t   reg_wdata,
    input  logic                    wdog_timeout,
    input  logic                    amp_fault,          // active low
    output qla_motor_pkg::cur_cmd_t cur_cmd,
    output qla_regmap_pkg::word_t   motor_status,
    output logic                    amp_enable_cmd,
    output logic                    amp_disable_pin     // 1 -> amplifier off
);
    import qla_motor_pkg::*;

    localparam int CMD_W = $bits(cur_cmd_t);

    logic amp_en;           // commanded enable
    logic safety_latch;     // set by watchdog or fault, cleared by enable write
    logic en_write;         // write carries a valid enable field
    logic en_set;           // host tries to enable the amplifier
    logic amp_en_nxt;
    logic safety_nxt;

    // --------------------
    // commanded current
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            cur_cmd <= '0;
        end else if (cmd_wen) begin
            cur_cmd <= reg_wdata[CMD_W-1:0];
        end
    end

    // --------------------
    // enable and safety
    assign en_write = mstat_wen && reg_wdata[AMP_EN_MASK_BIT];  // no mask, no change
    assign en_set   = en_write && reg_wdata[AMP_EN_BIT];

    assign amp_en_nxt = en_write ? reg_wdata[AMP_EN_BIT] : amp_en;

    // fault only counts while the amplifier is on
    always_comb begin
        if (en_set) begin
            safety_nxt = 1'b0;
        end else begin
            safety_nxt = safety_latch || wdog_timeout || (!amp_fault && amp_en);
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            amp_en          <= 1'b0;
            safety_latch    <= 1'b0;
            amp_disable_pin <= 1'b1;    // amplifiers off out of reset
            amp_enable_cmd  <= 1'b0;
        end else begin
            amp_en          <= amp_en_nxt;
            safety_latch    <= safety_nxt;
            amp_disable_pin <= !amp_en_nxt || safety_nxt;   // pin tracks next state
            amp_enable_cmd  <= en_set;  // one cycle, feeds wdog_clear
        end
    end

    // --------------------
    // status word
    always_comb begin
        motor_status                       = '0;
        motor_status[CMD_W-1:0]            = cur_cmd;
        motor_status[STAT_SAFETY_BIT]      = safety_latch;
        motor_status[STAT_NOT_DISABLE_BIT] = amp_en;
    end

endmodule

// ==== hw/qla_core.sv ====
// motor command core: host register bus, four motor channels and the quad DAC serializer
module qla_core (
    input  logic                      sysclk,
    input  logic                      rst_n,
    // host bus
    input  qla_regmap_pkg::addr_t     reg_waddr,
    input  qla_regmap_pkg::word_t     reg_wdata,
    input  logic                      reg_wen,
    input  logic                      blk_wen,
    input  qla_regmap_pkg::addr_t     reg_raddr,
    output qla_regmap_pkg::word_t     reg_rdata,
    // board and amplifiers
    input  logic [3:0]                board_id,
    input  logic                      wdog_timeout,
    input  qla_motor_pkg::chan_mask_t amp_fault,        // active low
    output logic                      wdog_clear,
    output qla_motor_pkg::chan_mask_t amp_disable_pin,
    // quad DAC
    output logic                      dac_sclk,
    output logic                      dac_mosi,
    output logic                      dac_csel,
    output logic                      dac_busy
);
    import qla_regmap_pkg::*;
    import qla_motor_pkg::*;

    chan_mask_t              cmd_wen;
    chan_mask_t              mstat_wen;
    chan_mask_t              amp_enable_cmd;
    logic                    dac_update;
    cur_cmd_t [NUM_CHAN-1:0] cur_cmd_all;
    word_t [NUM_CHAN-1:0]    motor_status_all;

    // any enable attempt clears the watchdog
    assign wdog_clear = |amp_enable_cmd;

    // --------------------
    reg_write_decode i_reg_write_decode (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .reg_waddr  (reg_waddr),
        .reg_wen    (reg_wen),
        .blk_wen    (blk_wen),
        .dac_busy   (dac_busy),
        .cmd_wen    (cmd_wen),
        .mstat_wen  (mstat_wen),
        .dac_update (dac_update)
    );

    // --------------------
    for (genvar k = 0; k < NUM_CHAN; k++) begin : g_chan    // g_chan[0] is motor 1
        motor_channel i_motor_channel (
            .sysclk          (sysclk),
            .rst_n           (rst_n),
            .cmd_wen         (cmd_wen[k]),
            .mstat_wen       (mstat_wen[k]),
            .reg_wdata       (reg_wdata),
            .wdog_timeout    (wdog_timeout),
            .amp_fault       (amp_fault[k]),
            .cur_cmd         (cur_cmd_all[k]),
            .motor_status    (motor_status_all[k]),
            .amp_enable_cmd  (amp_enable_cmd[k]),
            .amp_disable_pin (amp_disable_pin[k])
        );
    end

    // --------------------
    dac_serializer i_dac_serializer (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .dac_update (dac_update),
        .cmd_all    (cur_cmd_all),
        .dac_sclk   (dac_sclk),
        .dac_mosi   (dac_mosi),
        .dac_csel   (dac_csel),
        .dac_busy   (dac_busy)
    );

    reg_read_mux i_reg_read_mux (
        .reg_raddr        (reg_raddr),
        .board_id         (board_id),
        .wdog_timeout     (wdog_timeout),
        .amp_fault        (amp_fault),
        .motor_status_all (motor_status_all),
        .cur_cmd_all      (cur_cmd_all),
        .reg_rdata        (reg_rdata)
    );

endmodule

// ==== hw/qla_motor_pkg.sv ====
// motor package: channel count, command and status layout, quad DAC frame constants
package qla_motor_pkg;

    localparam int NUM_CHAN = 4;                // motor channels 1 to 4

    typedef logic [15:0]         cur_cmd_t;    // commanded current, DAC code
    typedef logic [NUM_CHAN-1:0] chan_mask_t;  // bit 0 is channel 1

    // --------------------
    // bits of a write to the motor status offset
    localparam int AMP_EN_BIT      = 8;        // requested enable state
    localparam int AMP_EN_MASK_BIT = 9;        // enable field is valid

    // bits of the motor status word, low 16 bits carry cur_cmd
    localparam int STAT_SAFETY_BIT      = 17;
    localparam int STAT_NOT_DISABLE_BIT = 29;

    // --------------------
    // quad DAC frame: command, address, data
    localparam int DAC_FRAME_BITS = 24;
    localparam logic [3:0] DAC_CMD_WRITE_UPDATE = 4'd3;   // write and update channel n
    localparam int DAC_HALF_PERIOD = 2;                   // sysclk cycles per sclk half

    // whole update: per frame one setup cycle (csel high) and one hold cycle
    localparam int DAC_UPDATE_CYCLES =
        NUM_CHAN * (DAC_FRAME_BITS * 2 * DAC_HALF_PERIOD + 2);

endpackage

// ==== hw/qla_regmap_pkg.sv ====
// register map package: host address fields, bank codes and channel register offsets
package qla_regmap_pkg;

    typedef logic [15:0] addr_t;        // host register address
    typedef logic [31:0] word_t;        // host data word

    typedef logic [3:0] bank_t;         // addr[15:12]
    typedef logic [3:0] chan_idx_t;     // addr[7:4], 0 is the board
    typedef logic [3:0] off_t;          // addr[3:0]

    // --------------------
    // bank codes
    localparam bank_t ADDR_MAIN = 4'h0;

    // channel register offsets
    localparam off_t OFF_BOARD_STATUS = 4'd0;   // channel 0 only
    localparam off_t OFF_DAC_CTRL     = 4'd1;   // commanded current
    localparam off_t OFF_MOTOR_STATUS = 4'd12;  // enable write, status read

    // --------------------
    // field extraction, same split for read and write side
    function automatic bank_t addr_bank(input addr_t addr);
        return addr[15:12];
    endfunction

    function automatic chan_idx_t addr_chan(input addr_t addr);
        return addr[7:4];
    endfunction

    function automatic off_t addr_off(input addr_t addr);
        return addr[3:0];
    endfunction

endpackage

// ==== hw/reg_read_mux.sv ====
// register read mux: board status and per-channel command or status, chosen by read address
module reg_read_mux (
    input  qla_regmap_pkg::addr_t                                 reg_raddr,
    input  logic [3:0]                                            board_id,
    input  logic                                                  wdog_timeout,
    input  qla_motor_pkg::chan_mask_t                             amp_fault,
    input  qla_regmap_pkg::word_t [qla_motor_pkg::NUM_CHAN-1:0]   motor_status_all,
    input  qla_motor_pkg::cur_cmd_t [qla_motor_pkg::NUM_CHAN-1:0] cur_cmd_all,
    output qla_regmap_pkg::word_t                                 reg_rdata
);
    import qla_regmap_pkg::*;
    import qla_motor_pkg::*;

    localparam int SEL_W = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;

    chan_idx_t         rchan;
    off_t              roff;
    logic [SEL_W-1:0]  sel;             // channel - 1
    chan_mask_t        safety_all;
    chan_mask_t        not_disable_all;
    logic [11:0]       amp_summary;
    word_t             board_status;

    assign rchan = addr_chan(reg_raddr);
    assign roff  = addr_off(reg_raddr);
    assign sel   = SEL_W'(rchan - 1'b1);

    // --------------------
    // board status, channel order 4..1 in each group
    always_comb begin
        for (int k = 0; k < NUM_CHAN; k++) begin
            safety_all[k]      = motor_status_all[k][STAT_SAFETY_BIT];
            not_disable_all[k] = motor_status_all[k][STAT_NOT_DISABLE_BIT];
        end
    end

    assign amp_summary  = {amp_fault, safety_all, not_disable_all};
    assign board_status = {4'b0, board_id, wdog_timeout, 11'b0, amp_summary};

    // --------------------
    // read select, anything unmapped reads 0
    always_comb begin
        reg_rdata = '0;
        if (addr_bank(reg_raddr) == ADDR_MAIN) begin
            if (rchan == '0) begin
                if (roff == OFF_BOARD_STATUS) begin
                    reg_rdata = board_status;
                end
            end else if (rchan <= chan_idx_t'(NUM_CHAN)) begin
                if (roff == OFF_DAC_CTRL) begin
                    reg_rdata = word_t'(cur_cmd_all[sel]);  // zero-extended
                end else if (roff == OFF_MOTOR_STATUS) begin
                    reg_rdata = motor_status_all[sel];
                end
            end
        end
    end

endmodule

// ==== hw/reg_write_decode.sv ====
// register write decode: per-channel write strobes and the deferred DAC update request
module reg_write_decode (
    input  logic                      sysclk,
    input  logic                      rst_n,
    input  qla_regmap_pkg::addr_t     reg_waddr,
    input  logic                      reg_wen,
    input  logic                      blk_wen,
    input  logic                      dac_busy,
    output qla_motor_pkg::chan_mask_t cmd_wen,
    output qla_motor_pkg::chan_mask_t mstat_wen,
    output logic                      dac_update
);
    import qla_regmap_pkg::*;
    import qla_motor_pkg::*;

    bank_t      wbank;
    chan_idx_t  wchan;
    off_t       woff;
    logic       main_bank;
    chan_mask_t chan_hit;       // one-hot channel select, bit 0 is channel 1
    logic       dac_waddr;      // DAC offset of any non-board channel
    logic       dac_write;
    logic       dac_req;        // pending update request

    // --------------------
    // address split
    assign wbank     = addr_bank(reg_waddr);
    assign wchan     = addr_chan(reg_waddr);
    assign woff      = addr_off(reg_waddr);
    assign main_bank = (wbank == ADDR_MAIN);

    always_comb begin
        for (int k = 0; k < NUM_CHAN; k++) begin
            chan_hit[k] = main_bank && (wchan == chan_idx_t'(k + 1));
        end
    end

    // per-channel strobes, channel 0 and 5..15 hit nothing
    assign cmd_wen   = (reg_wen && (woff == OFF_DAC_CTRL))     ? chan_hit : '0;
    assign mstat_wen = (reg_wen && (woff == OFF_MOTOR_STATUS)) ? chan_hit : '0;

    // --------------------
    // deferred DAC update
    // block write ends with blk_wen on the DAC offset, quadlet write leaves it low
    assign dac_waddr = main_bank && (wchan != '0) && (woff == OFF_DAC_CTRL);
    assign dac_write = dac_waddr && (reg_wen || blk_wen);

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            dac_req    <= 1'b0;
            dac_update <= 1'b0;
        end else begin
            if (dac_write) begin
                dac_req <= blk_wen;             // repeated requests merge here
            end else if (dac_req && !dac_busy) begin
                dac_req <= 1'b0;                // handed to the serializer
            end
            dac_update <= dac_req && !dac_busy; // one cycle after the hand-off
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then judge the log
rm -rf obj_dir sim.log
verilator --binary --assert --timing --top-module tb_qla -f sources.f -o sim_qla \
    && ./obj_dir/sim_qla +verilator+error+limit+1000 > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }
grep -q "test failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "test passed" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "PASS"

// ==== sources.f ====
hw/qla_regmap_pkg.sv
hw/qla_motor_pkg.sv
hw/reg_write_decode.sv
hw/motor_channel.sv
hw/dac_serializer.sv
hw/reg_read_mux.sv
hw/qla_core.sv
testbench/tb_clock.sv
testbench/qla_core_assert.sv
testbench/tb_qla.sv

// ==== testbench/qla_core_assert.sv ====
// qla_core checker: reference model of commands, enables and DAC requests with assertions
module qla_core_assert (
    input logic                      sysclk,
    input logic                      rst_n,
    input qla_regmap_pkg::addr_t     reg_waddr,
    input qla_regmap_pkg::word_t     reg_wdata,
    input logic                      reg_wen,
    input logic                      blk_wen,
    input qla_regmap_pkg::addr_t     reg_raddr,
    input qla_regmap_pkg::word_t     reg_rdata,
    input logic [3:0]                board_id,
    input logic                      wdog_timeout,
    input qla_motor_pkg::chan_mask_t amp_fault,
    input logic                      wdog_clear,
    input qla_motor_pkg::chan_mask_t amp_disable_pin,
    input logic                      dac_sclk,
    input logic                      dac_mosi,
    input logic                      dac_csel,
    input logic                      dac_busy,
    input logic                      dac_update     // internal pulse of the core
);
    import qla_regmap_pkg::*;
    import qla_motor_pkg::*;

    localparam int IDX_W = $clog2(NUM_CHAN);

    int fail_count = 0;

    cur_cmd_t [NUM_CHAN-1:0]   cmd_sh;      // commands as written by the host
    cur_cmd_t [NUM_CHAN-1:0]   cmd_snap;    // commands when the update starts
    chan_mask_t                en_sh;
    chan_mask_t                latch_sh;
    chan_mask_t                cmd_hit;
    chan_mask_t                en_hit;      // enable field valid, per channel
    logic                      en_set_any;
    logic                      dac_addr;
    logic                      req_sh;      // pending DAC request
    logic                      csel_q;
    logic                      frame_end;
    logic [IDX_W-1:0]          frame_idx;
    int                        busy_len;
    logic [DAC_FRAME_BITS-1:0] cap;         // last 24 bits seen on mosi
    logic [DAC_FRAME_BITS-1:0] exp_frame;
    word_t                     exp_rdata;

    // --------------------
    // write side, straight from the address map
    always_comb begin
        for (int k = 0; k < NUM_CHAN; k++) begin
            cmd_hit[k] = reg_wen && (reg_waddr[15:12] == ADDR_MAIN) &&
                         (reg_waddr[7:4] == chan_idx_t'(k + 1)) &&
                         (reg_waddr[3:0] == OFF_DAC_CTRL);
            en_hit[k]  = reg_wen && (reg_waddr[15:12] == ADDR_MAIN) &&
                         (reg_waddr[7:4] == chan_idx_t'(k + 1)) &&
                         (reg_waddr[3:0] == OFF_MOTOR_STATUS) && reg_wdata[AMP_EN_MASK_BIT];
        end
    end

    assign en_set_any = (|en_hit) && reg_wdata[AMP_EN_BIT];
    assign dac_addr   = (reg_waddr[15:12] == ADDR_MAIN) && (reg_waddr[7:4] != 4'h0) &&
                        (reg_waddr[3:0] == OFF_DAC_CTRL) && (reg_wen || blk_wen);
    assign frame_end  = dac_csel && !csel_q;
    assign exp_frame  = {DAC_CMD_WRITE_UPDATE, 4'(frame_idx), cmd_snap[frame_idx]};

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            cmd_sh    <= '0;
            en_sh     <= '0;
            latch_sh  <= '0;
            req_sh    <= 1'b0;
            csel_q    <= 1'b1;
            frame_idx <= '0;
            busy_len  <= 0;
        end else begin
            for (int k = 0; k < NUM_CHAN; k++) begin
                if (cmd_hit[k]) begin
                    cmd_sh[k] <= reg_wdata[15:0];
                end
                if (en_hit[k]) begin
                    en_sh[k] <= reg_wdata[AMP_EN_BIT];
                end
                if (en_hit[k] && reg_wdata[AMP_EN_BIT]) begin
                    latch_sh[k] <= 1'b0;    // enable attempt rearms
                end else if (wdog_timeout || (!amp_fault[k] && en_sh[k])) begin
                    latch_sh[k] <= 1'b1;
                end
            end
            if (dac_addr) begin
                req_sh <= blk_wen;
            end else if (dac_update) begin
                req_sh <= 1'b0;
            end
            if (dac_update) begin
                cmd_snap  <= cmd_sh;
                frame_idx <= '0;
            end else if (frame_end) begin
                frame_idx <= frame_idx + 1'b1;
            end
            csel_q   <= dac_csel;
            busy_len <= dac_busy ? busy_len + 1 : 0;
        end
    end

    always_ff @(posedge dac_sclk) begin
        cap <= {cap[DAC_FRAME_BITS-2:0], dac_mosi};     // DAC samples on the rise
    end

    // --------------------
    // expected read word
    always_comb begin
        exp_rdata = '0;
        if (reg_raddr[15:12] == ADDR_MAIN) begin
            if ((reg_raddr[7:4] == 4'h0) && (reg_raddr[3:0] == OFF_BOARD_STATUS)) begin
                exp_rdata = {4'h0, board_id, wdog_timeout, 11'h0, amp_fault, latch_sh, en_sh};
            end
            for (int k = 0; k < NUM_CHAN; k++) begin
                if (reg_raddr[7:4] == chan_idx_t'(k + 1)) begin
                    if (reg_raddr[3:0] == OFF_DAC_CTRL) begin
                        exp_rdata = {16'h0, cmd_sh[k]};
                    end else if (reg_raddr[3:0] == OFF_MOTOR_STATUS) begin
                        exp_rdata[15:0]                 = cmd_sh[k];
                        exp_rdata[STAT_SAFETY_BIT]      = latch_sh[k];
                        exp_rdata[STAT_NOT_DISABLE_BIT] = en_sh[k];
                    end
                end
            end
        end
    end

    // --------------------
    a_reset: assert property (@(posedge sysclk) !rst_n |=>
        (dac_csel && !dac_sclk && !dac_busy && !wdog_clear && (amp_disable_pin == '1)))
        else begin
            $error("Error reset outputs csel %h busy %h wdog_clear %h amp_disable_pin %h",
                   dac_csel, dac_busy, wdog_clear, amp_disable_pin);
            fail_count++;
        end

    a_rdata: assert property (@(posedge sysclk) disable iff (!rst_n) reg_rdata == exp_rdata)
        else begin
            $error("Error reg_rdata %h expected %h", $sampled(reg_rdata), $sampled(exp_rdata));
            fail_count++;
        end

    a_wdog_clear: assert property (@(posedge sysclk) disable iff (!rst_n)
        wdog_clear == $past(en_set_any))
        else begin
            $error("Error wdog_clear %h expected %h", $sampled(wdog_clear), !$sampled(wdog_clear));
            fail_count++;
        end

    a_disable_pin: assert property (@(posedge sysclk) disable iff (!rst_n)
        amp_disable_pin == (~en_sh | latch_sh))
        else begin
            $error("Error amp_disable_pin %h expected %h", $sampled(amp_disable_pin),
                   $sampled(~en_sh | latch_sh));
            fail_count++;
        end

    a_frame: assert property (@(posedge sysclk) disable iff (!rst_n) frame_end |-> cap == exp_frame)
        else begin
            $error("Error dac frame %h expected %h", $sampled(cap), $sampled(exp_frame));
            fail_count++;
        end

    a_busy_len: assert property (@(posedge sysclk) disable iff (!rst_n)
        $fell(dac_busy) |-> busy_len == DAC_UPDATE_CYCLES)
        else begin
            $error("Error dac_busy length %h expected %h", $sampled(busy_len), DAC_UPDATE_CYCLES);
            fail_count++;
        end

    a_busy_cause: assert property (@(posedge sysclk) disable iff (!rst_n)
        (($rose(dac_busy) |-> $past(dac_update)) and (dac_update |-> req_sh)))
        else begin
            $error("DAC update started with no pending request");
            fail_count++;
        end

    a_req_served: assert property (@(posedge sysclk) disable iff (!rst_n)
        (req_sh && !dac_busy && !dac_update) |=> dac_update)
        else begin
            $error("pending DAC request was not served once dac_busy was low");
            fail_count++;
        end

endmodule

bind qla_core qla_core_assert i_qla_core_assert (.*);

// ==== testbench/tb_clock.sv ====
// testbench clock and reset generator, 10 unit period with reset low for two rising edges
module tb_clock (
    output logic sysclk,
    output logic rst_n
);
    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 2;

    initial begin
        sysclk = 1'b0;
        forever #HALF_PERIOD sysclk = ~sysclk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge sysclk);
        #1;
        rst_n = 1'b1;   // released just after the edge, like all stimulus
    end

endmodule

// ==== testbench/tb_qla.sv ====
// testbench top: host writes, amplifier faults and DAC requests into the motor command core
module tb_qla;
    import qla_regmap_pkg::*;
    import qla_motor_pkg::*;

    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 150 + 3 * DAC_UPDATE_CYCLES;  // bus work plus three updates
    localparam int MAX_CYCLES  = TEST_CYCLES + 4 * DAC_UPDATE_CYCLES;
    localparam word_t EN_ON  = (word_t'(1) << AMP_EN_MASK_BIT) | (word_t'(1) << AMP_EN_BIT);
    localparam word_t EN_OFF = word_t'(1) << AMP_EN_MASK_BIT;

    logic       sysclk;
    logic       rst_n;
    addr_t      reg_waddr;
    word_t      reg_wdata;
    logic       reg_wen;
    logic       blk_wen;
    addr_t      reg_raddr;
    word_t      reg_rdata;
    logic [3:0] board_id;
    logic       wdog_timeout;
    chan_mask_t amp_fault;
    logic       wdog_clear;
    chan_mask_t amp_disable_pin;
    logic       dac_sclk;
    logic       dac_mosi;
    logic       dac_csel;
    logic       dac_busy;

    int          cycle_cnt   = 0;
    int          errs_before = 0;
    int          tests_ok    = 0;
    int          tests_bad   = 0;
    int          stray_chan [3] = '{0, 5, 15};     // no motor behind these
    logic [15:0] lfsr_state  = 16'd52577;
    word_t       rnd;

    tb_clock i_tb_clock (.sysclk(sysclk), .rst_n(rst_n));

    qla_core i_qla_core (
        .sysclk(sysclk), .rst_n(rst_n),
        .reg_waddr(reg_waddr), .reg_wdata(reg_wdata), .reg_wen(reg_wen), .blk_wen(blk_wen),
        .reg_raddr(reg_raddr), .reg_rdata(reg_rdata),
        .board_id(board_id), .wdog_timeout(wdog_timeout), .amp_fault(amp_fault),
        .wdog_clear(wdog_clear), .amp_disable_pin(amp_disable_pin),
        .dac_sclk(dac_sclk), .dac_mosi(dac_mosi), .dac_csel(dac_csel), .dac_busy(dac_busy)
    );

    // --------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];     // taps 16 14 13 11
        return {s[14:0], fb};
    endfunction

    task automatic rand_bits(input int n, output word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic addr_t chan_addr(input int ch, input off_t off);
        return {ADDR_MAIN, 4'h0, 4'(ch), off};
    endfunction

    task automatic next_cycle(input int n);
        repeat (n) @(posedge sysclk);
        #1;                                     // drive just after the edge
    endtask

    task automatic write_reg(input addr_t addr, input word_t data, input logic blk);
        reg_waddr = addr;
        reg_raddr = addr;                       // readback shows one cycle later
        reg_wdata = data;
        reg_wen   = 1'b1;
        blk_wen   = blk;
        next_cycle(1);
        reg_wen   = 1'b0;
        blk_wen   = 1'b0;
    endtask

    task automatic wait_busy(input logic level);
        while (dac_busy !== level) next_cycle(1);
    endtask

    task automatic report(input int num, input string name);
        int errs;
        errs = i_qla_core.i_qla_core_assert.fail_count - errs_before;
        if (errs == 0) begin
            $display("case %0d %s: ok", num, name);
            tests_ok++;
        end else begin
            $display("case %0d %s: %0d assertion errors", num, name, errs);
            tests_bad++;
        end
        errs_before = i_qla_core.i_qla_core_assert.fail_count;
    endtask

    // --------------------
    always @(posedge sysclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        reg_waddr    = '0;
        reg_wdata    = '0;
        reg_wen      = 1'b0;
        blk_wen      = 1'b0;
        reg_raddr    = '0;
        board_id     = 4'h9;
        wdog_timeout = 1'b0;
        amp_fault    = '1;                      // no faults
        wait (rst_n === 1'b1);
        next_cycle(2);
        report(1, "reset");

        for (int ch = 1; ch <= NUM_CHAN; ch++) begin
            rand_bits(32, rnd);
            write_reg(chan_addr(ch, OFF_DAC_CTRL), rnd, 1'b0);
            next_cycle(1);
        end
        foreach (stray_chan[i]) begin
            rand_bits(32, rnd);
            write_reg(chan_addr(stray_chan[i], OFF_DAC_CTRL), rnd, 1'b0);
            next_cycle(1);
        end
        for (int ch = 1; ch <= NUM_CHAN; ch++) begin
            reg_raddr = chan_addr(ch, OFF_DAC_CTRL);    // strays left these alone
            next_cycle(1);
        end
        report(2, "command readback");

        rand_bits(16, rnd);
        write_reg(chan_addr(1, OFF_DAC_CTRL), rnd, 1'b1);
        wait_busy(1'b1);
        wait_busy(1'b0);
        next_cycle(2);
        report(3, "dac frames");

        write_reg(chan_addr(1, OFF_MOTOR_STATUS), word_t'(1) << AMP_EN_BIT, 1'b0);  // no mask
        next_cycle(2);
        write_reg(chan_addr(2, OFF_MOTOR_STATUS), EN_ON, 1'b0);
        next_cycle(2);
        write_reg(chan_addr(2, OFF_MOTOR_STATUS), '0, 1'b0);   // stays enabled
        next_cycle(2);
        for (int ch = 1; ch <= NUM_CHAN; ch++) begin
            write_reg(chan_addr(ch, OFF_MOTOR_STATUS), EN_ON, 1'b0);
        end
        write_reg(chan_addr(3, OFF_MOTOR_STATUS), EN_OFF, 1'b0);
        next_cycle(2);
        report(4, "enable and watchdog clear");

        reg_raddr    = chan_addr(1, OFF_MOTOR_STATUS);
        amp_fault[0] = 1'b0;
        next_cycle(1);
        amp_fault[0] = 1'b1;
        next_cycle(3);
        amp_fault[2] = 1'b0;                    // channel 3 off, no latch
        next_cycle(2);
        amp_fault    = '1;
        reg_raddr    = chan_addr(0, OFF_BOARD_STATUS);
        wdog_timeout = 1'b1;
        next_cycle(1);
        wdog_timeout = 1'b0;
        next_cycle(3);
        write_reg(chan_addr(1, OFF_MOTOR_STATUS), EN_ON, 1'b0);
        next_cycle(2);
        report(5, "safety latch");

        rand_bits(16, rnd);
        write_reg(chan_addr(3, OFF_DAC_CTRL), rnd, 1'b1);
        wait_busy(1'b1);
        next_cycle(20);
        rand_bits(16, rnd);
        write_reg(chan_addr(4, OFF_DAC_CTRL), rnd, 1'b1);  // frames in flight keep old value
        next_cycle(5);
        rand_bits(16, rnd);
        write_reg(chan_addr(2, OFF_DAC_CTRL), rnd, 1'b1);  // merges with the one above
        wait_busy(1'b0);
        wait_busy(1'b1);
        wait_busy(1'b0);
        next_cycle(10);
        report(6, "deferred update");

        $display("cases %0d, ok %0d, failing %0d, assertion errors %0d", NUM_TESTS, tests_ok,
                 tests_bad, i_qla_core.i_qla_core_assert.fail_count);
        if ((tests_bad == 0) && (i_qla_core.i_qla_core_assert.fail_count == 0)) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
